// ==== project.f ====
src/rw_pkg.sv
src/rw_config_regs.sv
src/addr_fifo.sv
src/bary_shader.sv
src/pixel_sequencer.sv
src/result_writer.sv
sim/result_writer_sva.sv
sim/tb_result_writer.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_result_writer > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_result_writer > sim.log 2>&1
grep -qx "Simulation PASSED" sim.log && echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }

// ==== sim/tb_result_writer.sv ====
module tb_result_writer;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 16;
    localparam int N_WORDS      = 15;
    localparam int MAX_CYCLES   = 300 * N_WORDS + RESET_CYCLES;

    logic                   clk;
    logic                   globalreset;
    logic [1:0]             valid;          // bit 0 group 01, bit 1 group 10
    logic [1:0]             push_sel;
    rw_pkg::tri_id_t        id_r [2][3];
    logic                   hit_r [2][3];
    rw_pkg::bary_t          u_r [2][3];
    rw_pkg::bary_t          v_r [2][3];
    rw_pkg::addr_t          addr;
    rw_pkg::shade_word_t    shade_data;
    logic                   shade_data_ready;
    logic                   ack;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    rw_pkg::apb_addr_t      paddr;
    rw_pkg::apb_data_t      pwdata;
    rw_pkg::tri_id_t        tri_id;
    logic                   want_shade_data;
    rw_pkg::out_word_t      data_out;
    rw_pkg::addr_t          addr_out;
    logic                   write;
    rw_pkg::apb_data_t      prdata;
    logic                   pready;

    rw_pkg::shade_word_t    shade_mem [64];  // ids 32..63 interpolated
    rw_pkg::addr_t          exp_addr [$];
    rw_pkg::out_word_t      exp_data [$];
    rw_pkg::colour_t        bk_model;
    int                     errors;
    int                     checks;
    int                     cycles;

    result_writer #(.FIFO_DEPTH(3)) i_result_writer (
        .clk(clk), .globalreset(globalreset),
        .valid_01(valid[0]), .valid_10(valid[1]),
        .id_01_a(id_r[0][0]), .id_01_b(id_r[0][1]), .id_01_c(id_r[0][2]),
        .id_10_a(id_r[1][0]), .id_10_b(id_r[1][1]), .id_10_c(id_r[1][2]),
        .hit_01_a(hit_r[0][0]), .hit_01_b(hit_r[0][1]), .hit_01_c(hit_r[0][2]),
        .hit_10_a(hit_r[1][0]), .hit_10_b(hit_r[1][1]), .hit_10_c(hit_r[1][2]),
        .u_01_a(u_r[0][0]), .u_01_b(u_r[0][1]), .u_01_c(u_r[0][2]),
        .v_01_a(v_r[0][0]), .v_01_b(v_r[0][1]), .v_01_c(v_r[0][2]),
        .u_10_a(u_r[1][0]), .u_10_b(u_r[1][1]), .u_10_c(u_r[1][2]),
        .v_10_a(v_r[1][0]), .v_10_b(v_r[1][1]), .v_10_c(v_r[1][2]),
        .addr(addr), .as_01(push_sel[0]), .as_10(push_sel[1]),
        .shade_data(shade_data), .shade_data_ready(shade_data_ready), .ack(ack),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .tri_id(tri_id), .want_shade_data(want_shade_data), .data_out(data_out),
        .addr_out(addr_out), .write(write), .prdata(prdata), .pready(pready)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES)
        begin
            $display("timeout: run stopped after %0d cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ************************************************************
    // shading memory and ack responders
    // ************************************************************

    always
    begin
        @(negedge clk);
        if (want_shade_data)
        begin
            repeat ($urandom % 4) @(negedge clk);
            shade_data       = shade_mem[tri_id[5:0]];
            shade_data_ready = 1'b1;
            @(negedge clk);
            shade_data_ready = 1'b0;
        end
    end

    always
    begin
        @(negedge clk);
        if (write)
        begin
            repeat ($urandom % 5) @(negedge clk);
            ack = 1'b1;
            @(negedge clk);
            ack = 1'b0;
        end
    end

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] want);
        checks = checks + 1;
        assert (got === want)
        else
        begin
            errors = errors + 1;
            $display("Error %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    // words leave in the order they were queued
    always @(posedge clk)
    begin
        if (write && ack)
        begin
            if (exp_data.size() == 0)
            begin
                errors = errors + 1;
                $display("write to %h arrived with nothing expected", addr_out);
            end
            else
            begin
                check_value("addr_out", 64'(addr_out), 64'(exp_addr.pop_front()));
                check_value("data_out", data_out, exp_data.pop_front());
            end
        end
    end

    // ************************************************************
    // reference model
    // ************************************************************

    function automatic rw_pkg::colour_t pixel_colour(
        input logic                 hit,
        input rw_pkg::shade_word_t  wd,
        input rw_pkg::bary_t        u,
        input rw_pkg::bary_t        v,
        input rw_pkg::colour_t      bk
    );
        int              w;
        int              sum;
        rw_pkg::colour_t col;
        w = 255 - int'(u) - int'(v);
        if (!hit)
        begin
            col = bk;
        end
        else if (!wd[63])
        begin
            col = wd[20:0];     // flat, texture words too
        end
        else
        begin
            for (int c = 0; c < 3; c++)
            begin
                sum = int'(u) * int'(wd[42 + c*7 +: 7]) + int'(v) * int'(wd[21 + c*7 +: 7])
                    + w * int'(wd[c*7 +: 7]);
                col[c*7 +: 7] = 7'(sum / 256);
            end
        end
        return col;
    endfunction

    function automatic rw_pkg::out_word_t expect_word(input int g);
        rw_pkg::colour_t col [3];
        for (int p = 0; p < 3; p++)
        begin
            col[p] = pixel_colour(hit_r[g][p], shade_mem[id_r[g][p][5:0]],
                                  u_r[g][p], v_r[g][p], bk_model);
        end
        return {1'b0, col[0], col[1], col[2]};
    endfunction

    // ************************************************************
    // stimulus
    // ************************************************************

    task automatic apb_write(input rw_pkg::apb_addr_t a, input rw_pkg::apb_data_t d);
        @(negedge clk);
        psel   = 1'b1;
        pwrite = 1'b1;
        paddr  = a;
        pwdata = d;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input rw_pkg::apb_addr_t a, output rw_pkg::apb_data_t d);
        @(negedge clk);
        psel   = 1'b1;
        pwrite = 1'b0;
        paddr  = a;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        d = prdata;
        check_value("pready", 64'(pready), 64'd1);   // zero wait states
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic push_addr(input int g, input rw_pkg::addr_t a);
        @(negedge clk);
        addr        = a;
        push_sel[g] = 1'b1;
        @(negedge clk);
        push_sel[g] = 1'b0;
    endtask

    // mode 0 all miss, 1 flat or miss, 2 interpolated, 3 anything
    task automatic set_group(input int g, input int mode);
        for (int p = 0; p < 3; p++)
        begin
            hit_r[g][p] = (mode == 2) || (mode != 0 && ($urandom % 3) != 0);
            id_r[g][p]  = 16'((mode == 2) ? 32 + $urandom % 32 :
                              (mode == 3) ? $urandom % 64 : $urandom % 32);
            u_r[g][p]   = 8'($urandom % 256);
            v_r[g][p]   = 8'($urandom % (256 - int'(u_r[g][p])));
        end
    endtask

    task automatic send_group(input int g, input int mode);
        rw_pkg::addr_t a;
        a = 18'($urandom);
        push_addr(g, a);
        set_group(g, mode);
        exp_addr.push_back(a);
        exp_data.push_back(expect_word(g));
        valid[g] = 1'b1;
        @(negedge clk);
        valid[g] = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_data.size() != 0)
        begin
            @(negedge clk);
        end
    endtask

    task automatic report(input string name, input int errs_before);
        if (errors == errs_before)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    initial
    begin
        int                e;
        rw_pkg::apb_data_t rd;
        rw_pkg::apb_data_t wv;
        rw_pkg::addr_t     a_q [2][3];
        clk = 1'b0;
        globalreset = 1'b1;
        valid = '0;
        push_sel = '0;
        addr = '0;
        shade_data = '0;
        shade_data_ready = 1'b0;
        ack = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        errors = 0;
        checks = 0;
        cycles = 0;
        bk_model = '0;
        void'($urandom(32'hc6a7));
        for (int g = 0; g < 2; g++)
        begin
            for (int p = 0; p < 3; p++)
            begin
                id_r[g][p]  = '0;
                hit_r[g][p] = 1'b0;
                u_r[g][p]   = '0;
                v_r[g][p]   = '0;
            end
        end
        for (int i = 0; i < 64; i++)
        begin
            shade_mem[i] = {i[5], 31'($urandom), 32'($urandom)};
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        globalreset = 1'b0;

        e = errors;
        check_value("write", 64'(write), 64'd0);
        check_value("want_shade_data", 64'(want_shade_data), 64'd0);
        check_value("tri_id", 64'(tri_id), 64'd0);
        apb_read(rw_pkg::BKCOLOUR_OFFSET, rd);
        check_value("background after reset", 64'(rd), 64'd0);
        report("1 reset state", e);

        e = errors;
        wv = $urandom;
        apb_write(rw_pkg::BKCOLOUR_OFFSET, wv);
        bk_model = wv[20:0];
        apb_read(rw_pkg::BKCOLOUR_OFFSET, rd);
        check_value("background readback", 64'(rd), 64'(bk_model));
        apb_read(8'h04, rd);
        check_value("read at offset 04", 64'(rd), 64'd0);
        report("2 background register", e);

        e = errors;
        send_group(0, 0);
        wait_drained();
        report("3 group 01 all miss", e);

        e = errors;
        repeat (4)
        begin
            send_group(1, 1);
            wait_drained();
        end
        report("4 group 10 flat and miss", e);

        e = errors;
        for (int i = 0; i < 4; i++)
        begin
            send_group(i % 2, 2);
            wait_drained();
        end
        report("5 interpolated hits", e);

        // three addresses queued per group before any valid
        e = errors;
        for (int k = 0; k < 3; k++)
        begin
            for (int g = 0; g < 2; g++)
            begin
                a_q[g][k] = 18'($urandom);
                push_addr(g, a_q[g][k]);
            end
        end
        for (int k = 0; k < 3; k++)
        begin
            @(negedge clk);
            set_group(0, 3);
            set_group(1, 3);
            for (int g = 0; g < 2; g++)
            begin
                exp_addr.push_back(a_q[g][k]);
                exp_data.push_back(expect_word(g));
            end
            valid = 2'b11;
            @(negedge clk);
            valid = 2'b00;
            wait_drained();
        end
        report("6 both groups pending", e);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/result_writer_sva.sv ====
module result_writer_sva (
    input  logic                clk,
    input  logic                globalreset,
    input  logic                want_shade_data,
    input  logic                shade_data_ready,
    input  rw_pkg::tri_id_t     tri_id,
    input  logic                write,
    input  logic                ack,
    input  rw_pkg::out_word_t   data_out,
    input  rw_pkg::addr_t       addr_out
);

    timeunit 1ns;
    timeprecision 100ps;

    // id held until the memory answers
    a_tri_id_held: assert property (
        @(posedge clk) disable iff (globalreset)
        (want_shade_data && !shade_data_ready) |=> (want_shade_data && $stable(tri_id))
    ) else $error("tri_id changed while the shading fetch was waiting");

    a_write_held: assert property (
        @(posedge clk) disable iff (globalreset)
        (write && !ack) |=> (write && $stable(data_out) && $stable(addr_out))
    ) else $error("write word or address changed before ack");

    // one ack ends one write, no fetch straight after
    a_ack_to_idle: assert property (
        @(posedge clk) disable iff (globalreset)
        (write && ack) |=> (!write && !want_shade_data)
    ) else $error("write or want_shade_data high in the cycle after ack");

endmodule

bind pixel_sequencer result_writer_sva i_sva (
    .clk(clk), .globalreset(globalreset),
    .want_shade_data(want_shade_data), .shade_data_ready(shade_data_ready),
    .tri_id(tri_id), .write(write), .ack(ack),
    .data_out(data_out), .addr_out(addr_out)
);

// ==== src/result_writer.sv ====
module result_writer #(
    parameter int FIFO_DEPTH = 3
) (
    input  logic                    clk,
    input  logic                    globalreset,
    input  logic                    valid_01,
    input  logic                    valid_10,
    input  rw_pkg::tri_id_t         id_01_a,
    input  rw_pkg::tri_id_t         id_01_b,
    input  rw_pkg::tri_id_t         id_01_c,
    input  rw_pkg::tri_id_t         id_10_a,
    input  rw_pkg::tri_id_t         id_10_b,
    input  rw_pkg::tri_id_t         id_10_c,
    input  logic                    hit_01_a,
    input  logic                    hit_01_b,
    input  logic                    hit_01_c,
    input  logic                    hit_10_a,
    input  logic                    hit_10_b,
    input  logic                    hit_10_c,
    input  rw_pkg::bary_t           u_01_a,
    input  rw_pkg::bary_t           u_01_b,
    input  rw_pkg::bary_t           u_01_c,
    input  rw_pkg::bary_t           v_01_a,
    input  rw_pkg::bary_t           v_01_b,
    input  rw_pkg::bary_t           v_01_c,
    input  rw_pkg::bary_t           u_10_a,
    input  rw_pkg::bary_t           u_10_b,
    input  rw_pkg::bary_t           u_10_c,
    input  rw_pkg::bary_t           v_10_a,
    input  rw_pkg::bary_t           v_10_b,
    input  rw_pkg::bary_t           v_10_c,
    input  rw_pkg::addr_t           addr,
    input  logic                    as_01,
    input  logic                    as_10,
    input  rw_pkg::shade_word_t     shade_data,
    input  logic                    shade_data_ready,
    input  logic                    ack,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  rw_pkg::apb_addr_t       paddr,
    input  rw_pkg::apb_data_t       pwdata,
    output rw_pkg::tri_id_t         tri_id,
    output logic                    want_shade_data,
    output rw_pkg::out_word_t       data_out,
    output rw_pkg::addr_t           addr_out,
    output logic                    write,
    output rw_pkg::apb_data_t       prdata,
    output logic                    pready
);

    rw_pkg::colour_t    bk_colour;
    rw_pkg::colour_t    shaded_colour;
    rw_pkg::addr_t      head_01;
    rw_pkg::addr_t      head_10;
    logic               pop_01;
    logic               pop_10;
    logic [2:0]         shade_sel;

    rw_config_regs i_config_regs (
        .clk(clk), .globalreset(globalreset),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .bk_colour(bk_colour)
    );

    // one address queue per ray group
    addr_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo_01 (
        .clk(clk), .globalreset(globalreset),
        .push(as_01), .din(addr), .pop(pop_01), .head(head_01)
    );

    addr_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo_10 (
        .clk(clk), .globalreset(globalreset),
        .push(as_10), .din(addr), .pop(pop_10), .head(head_10)
    );

    bary_shader i_bary_shader (
        .clk(clk), .shade_sel(shade_sel),
        .u_01_a(u_01_a), .u_01_b(u_01_b), .u_01_c(u_01_c),
        .v_01_a(v_01_a), .v_01_b(v_01_b), .v_01_c(v_01_c),
        .u_10_a(u_10_a), .u_10_b(u_10_b), .u_10_c(u_10_c),
        .v_10_a(v_10_a), .v_10_b(v_10_b), .v_10_c(v_10_c),
        .shade_data(shade_data), .shaded_colour(shaded_colour)
    );

    pixel_sequencer i_pixel_sequencer (
        .clk(clk), .globalreset(globalreset),
        .valid_01(valid_01), .valid_10(valid_10),
        .id_01_a(id_01_a), .id_01_b(id_01_b), .id_01_c(id_01_c),
        .id_10_a(id_10_a), .id_10_b(id_10_b), .id_10_c(id_10_c),
        .hit_01_a(hit_01_a), .hit_01_b(hit_01_b), .hit_01_c(hit_01_c),
        .hit_10_a(hit_10_a), .hit_10_b(hit_10_b), .hit_10_c(hit_10_c),
        .shade_data(shade_data), .shade_data_ready(shade_data_ready),
        .shaded_colour(shaded_colour), .bk_colour(bk_colour),
        .head_01(head_01), .head_10(head_10), .ack(ack),
        .tri_id(tri_id), .want_shade_data(want_shade_data),
        .shade_sel(shade_sel), .pop_01(pop_01), .pop_10(pop_10),
        .data_out(data_out), .addr_out(addr_out), .write(write)
    );

endmodule

// ==== src/pixel_sequencer.sv ====
module pixel_sequencer (
    input  logic                    clk,
    input  logic                    globalreset,
    input  logic                    valid_01,
    input  logic                    valid_10,
    input  rw_pkg::tri_id_t         id_01_a,
    input  rw_pkg::tri_id_t         id_01_b,
    input  rw_pkg::tri_id_t         id_01_c,
    input  rw_pkg::tri_id_t         id_10_a,
    input  rw_pkg::tri_id_t         id_10_b,
    input  rw_pkg::tri_id_t         id_10_c,
    input  logic                    hit_01_a,
    input  logic                    hit_01_b,
    input  logic                    hit_01_c,
    input  logic                    hit_10_a,
    input  logic                    hit_10_b,
    input  logic                    hit_10_c,
    input  rw_pkg::shade_word_t     shade_data,
    input  logic                    shade_data_ready,
    input  rw_pkg::colour_t         shaded_colour,
    input  rw_pkg::colour_t         bk_colour,
    input  rw_pkg::addr_t           head_01,
    input  rw_pkg::addr_t           head_10,
    input  logic                    ack,
    output rw_pkg::tri_id_t         tri_id,
    output logic                    want_shade_data,
    output logic [2:0]              shade_sel,
    output logic                    pop_01,
    output logic                    pop_10,
    output rw_pkg::out_word_t       data_out,
    output rw_pkg::addr_t           addr_out,
    output logic                    write
);

    rw_pkg::seq_state_t state;
    logic               pending_01;
    logic               pending_10;
    logic               grp;            // 0 -> group 01, 1 -> group 10
    logic [1:0]         pix_idx;        // a, b, c
    rw_pkg::colour_t    pix_colour [3];
    rw_pkg::tri_id_t    id_sel;
    logic               hit_sel;
    logic               interp;

    // ************************************************************
    // pixel select
    // ************************************************************

    always_comb
    begin
        case (pix_idx)
            2'd0:
            begin
                id_sel  = grp ? id_10_a : id_01_a;
                hit_sel = grp ? hit_10_a : hit_01_a;
            end
            2'd1:
            begin
                id_sel  = grp ? id_10_b : id_01_b;
                hit_sel = grp ? hit_10_b : hit_01_b;
            end
            default:
            begin
                id_sel  = grp ? id_10_c : id_01_c;
                hit_sel = grp ? hit_10_c : hit_01_c;
            end
        endcase
    end

    assign interp    = hit_sel & shade_data[63];   // texture mode falls to flat
    assign shade_sel = {grp, pix_idx};

    assign want_shade_data = (state == rw_pkg::FETCH);
    assign tri_id          = want_shade_data ? id_sel : '0;

    assign write    = (state == rw_pkg::WRITE);
    assign data_out = {1'b0, pix_colour[0], pix_colour[1], pix_colour[2]};
    assign addr_out = grp ? head_10 : head_01;
    assign pop_01   = write & ack & ~grp;
    assign pop_10   = write & ack & grp;

    // ************************************************************
    // control FSM
    // ************************************************************

    always_ff @(posedge clk)
    begin
        if (globalreset)
        begin
            state      <= rw_pkg::IDLE;
            pending_01 <= 1'b0;
            pending_10 <= 1'b0;
            grp        <= 1'b0;
            pix_idx    <= 2'd0;
        end
        else
        begin
            // new valid beats the clearing ack
            pending_01 <= valid_01 | (pending_01 & ~pop_01);
            pending_10 <= valid_10 | (pending_10 & ~pop_10);
            case (state)
                rw_pkg::IDLE:
                begin
                    pix_idx <= 2'd0;
                    if (pending_01)
                    begin
                        grp   <= 1'b0;  // 01 first
                        state <= rw_pkg::FETCH;
                    end
                    else if (pending_10)
                    begin
                        grp   <= 1'b1;
                        state <= rw_pkg::FETCH;
                    end
                end
                rw_pkg::FETCH:
                begin
                    if (shade_data_ready)
                    begin
                        if (interp)
                        begin
                            state <= rw_pkg::SHADE_WAIT;
                        end
                        else if (pix_idx == 2'd2)
                        begin
                            state <= rw_pkg::WRITE;
                        end
                        else
                        begin
                            pix_idx <= pix_idx + 2'd1;
                        end
                    end
                end
                rw_pkg::SHADE_WAIT:
                begin
                    state <= rw_pkg::SHADE_CAPTURE;
                end
                rw_pkg::SHADE_CAPTURE:
                begin
                    if (pix_idx == 2'd2)
                    begin
                        state <= rw_pkg::WRITE;
                    end
                    else
                    begin
                        pix_idx <= pix_idx + 2'd1;
                        state   <= rw_pkg::FETCH;
                    end
                end
                rw_pkg::WRITE:
                begin
                    if (ack)
                    begin
                        state <= rw_pkg::IDLE;
                    end
                end
                default:
                begin
                    state <= rw_pkg::IDLE;
                end
            endcase
        end
    end

    // pixel colours
    always_ff @(posedge clk)
    begin
        if (state == rw_pkg::FETCH && shade_data_ready && !interp)
        begin
            pix_colour[pix_idx] <= hit_sel ? shade_data[20:0] : bk_colour;
        end
        else if (state == rw_pkg::SHADE_CAPTURE)
        begin
            pix_colour[pix_idx] <= shaded_colour;
        end
    end

endmodule

// ==== src/bary_shader.sv ====
module bary_shader (
    input  logic                    clk,
    input  logic [2:0]              shade_sel,     // {group, pixel}
    input  rw_pkg::bary_t           u_01_a,
    input  rw_pkg::bary_t           u_01_b,
    input  rw_pkg::bary_t           u_01_c,
    input  rw_pkg::bary_t           v_01_a,
    input  rw_pkg::bary_t           v_01_b,
    input  rw_pkg::bary_t           v_01_c,
    input  rw_pkg::bary_t           u_10_a,
    input  rw_pkg::bary_t           u_10_b,
    input  rw_pkg::bary_t           u_10_c,
    input  rw_pkg::bary_t           v_10_a,
    input  rw_pkg::bary_t           v_10_b,
    input  rw_pkg::bary_t           v_10_c,
    input  rw_pkg::shade_word_t     shade_data,
    output rw_pkg::colour_t         shaded_colour
);

    rw_pkg::bary_t      u_sel;
    rw_pkg::bary_t      v_sel;
    rw_pkg::bary_t      u_q;
    rw_pkg::bary_t      v_q;
    rw_pkg::bary_t      w_q;
    rw_pkg::colour_t    col_u_q;
    rw_pkg::colour_t    col_v_q;
    rw_pkg::colour_t    col_w_q;
    logic [14:0]        prod_u [3];
    logic [14:0]        prod_v [3];
    logic [14:0]        prod_w [3];
    logic [16:0]        sum [3];
    rw_pkg::chan_t      chan [3];   // 0 blue, 1 green, 2 red

    always_comb
    begin
        case (shade_sel)
            3'b000: {u_sel, v_sel} = {u_01_a, v_01_a};
            3'b001: {u_sel, v_sel} = {u_01_b, v_01_b};
            3'b010: {u_sel, v_sel} = {u_01_c, v_01_c};
            3'b100: {u_sel, v_sel} = {u_10_a, v_10_a};
            3'b101: {u_sel, v_sel} = {u_10_b, v_10_b};
            3'b110: {u_sel, v_sel} = {u_10_c, v_10_c};
            default: {u_sel, v_sel} = '0;
        endcase
    end

    // ************************************************************
    // stage 1: weights and vertex colours
    // ************************************************************

    always_ff @(posedge clk)
    begin
        u_q     <= u_sel;
        v_q     <= v_sel;
        w_q     <= 8'd255 - u_sel - v_sel;
        col_u_q <= shade_data[62:42];
        col_v_q <= shade_data[41:21];
        col_w_q <= shade_data[20:0];
    end

    // ************************************************************
    // stage 2: nine products
    // ************************************************************

    always_ff @(posedge clk)
    begin
        for (int c = 0; c < 3; c++)
        begin
            prod_u[c] <= u_q * col_u_q[c*7 +: 7];
            prod_v[c] <= v_q * col_v_q[c*7 +: 7];
            prod_w[c] <= w_q * col_w_q[c*7 +: 7];
        end
    end

    always_comb
    begin
        for (int c = 0; c < 3; c++)
        begin
            sum[c]  = 17'(prod_u[c]) + 17'(prod_v[c]) + 17'(prod_w[c]);
            chan[c] = sum[c][14:8];     // divide by 256
        end
    end

    assign shaded_colour = {chan[2], chan[1], chan[0]};

endmodule

// ==== src/addr_fifo.sv ====
module addr_fifo #(
    parameter int FIFO_DEPTH = 3
) (
    input  logic            clk,
    input  logic            globalreset,
    input  logic            push,
    input  rw_pkg::addr_t   din,
    input  logic            pop,
    output rw_pkg::addr_t   head
);

    localparam int CW = $clog2(FIFO_DEPTH + 1);

    rw_pkg::addr_t  mem [FIFO_DEPTH];
    logic [CW-1:0]  count;
    logic [CW-1:0]  wr_idx;
    logic           do_push;
    logic           do_pop;

    assign do_pop  = pop & (count != '0);
    // a full fifo still takes a push when the head leaves in the same cycle
    assign do_push = push & ((count != CW'(FIFO_DEPTH)) | do_pop);
    assign wr_idx  = count - CW'(do_pop);

    assign head = (count == '0) ? '0 : mem[0];

    always_ff @(posedge clk)
    begin
        if (globalreset)
        begin
            count <= '0;
        end
        else
        begin
            count <= count + CW'(do_push) - CW'(do_pop);
        end
    end

    // shift toward the head, then store at the tail
    always_ff @(posedge clk)
    begin
        if (do_pop)
        begin
            for (int i = 0; i < FIFO_DEPTH - 1; i++)
            begin
                mem[i] <= mem[i + 1];
            end
        end
        if (do_push)
        begin
            mem[wr_idx] <= din;
        end
    end

endmodule

// ==== src/rw_config_regs.sv ====
module rw_config_regs (
    input  logic                clk,
    input  logic                globalreset,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  rw_pkg::apb_addr_t   paddr,
    input  rw_pkg::apb_data_t   pwdata,
    output rw_pkg::apb_data_t   prdata,
    output logic                pready,
    output rw_pkg::colour_t     bk_colour
);

    logic hit_bk;
    logic wr_en;
    logic rd_en;

    // ************************************************************
    // decode
    // ************************************************************

    assign hit_bk = (paddr == rw_pkg::BKCOLOUR_OFFSET);
    assign wr_en  = psel & penable & pwrite;
    assign rd_en  = psel & ~pwrite;

    assign pready = 1'b1;   // no wait states

    // ************************************************************
    // background colour register
    // ************************************************************

    always_ff @(posedge clk)
    begin
        if (globalreset)
        begin
            bk_colour <= '0;
        end
        else if (wr_en && hit_bk)
        begin
            bk_colour <= pwdata[20:0];  // upper bits dropped
        end
    end

    // read mux, open during setup and enable phase
    always_comb
    begin
        if (rd_en && hit_bk)
        begin
            prdata = rw_pkg::apb_data_t'(bk_colour);
        end
        else
        begin
            prdata = '0;
        end
    end

endmodule

// ==== src/rw_pkg.sv ====
package rw_pkg;

    // ************************************************************
    // widths that carry a meaning
    // ************************************************************

    typedef logic [17:0] addr_t;        // frame buffer word address
    typedef logic [15:0] tri_id_t;
    typedef logic [7:0]  bary_t;        // barycentric weight, 0..255
    typedef logic [6:0]  chan_t;

    // red 20:14, green 13:7, blue 6:0
    typedef logic [20:0] colour_t;

    // bit 63 set -> interpolated, u/v/w vertex colours at 62:42, 41:21, 20:0
    // otherwise flat, colour in 20:0
    typedef logic [63:0] shade_word_t;

    // {1'b0, pixel a, pixel b, pixel c}
    typedef logic [63:0] out_word_t;

    // ************************************************************
    // register access
    // ************************************************************

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam apb_addr_t BKCOLOUR_OFFSET = 8'h00;

    // ************************************************************
    // sequencer
    // ************************************************************

    typedef enum logic [2:0] {
        IDLE,
        FETCH,          // waiting on shading memory
        SHADE_WAIT,
        SHADE_CAPTURE,  // blend result ready
        WRITE
    } seq_state_t;

endpackage
